// File: copperv_params.svh
`ifndef COPPERV_PARAMS_SVH
`define COPPERV_PARAMS_SVH

// ----------------------------------------
// Widths
// ----------------------------------------
`define WORD_WIDTH          32
`define REG_ADDR_WIDTH      5
`define INST_TYPE_WIDTH     3
`define FUNCT_WIDTH         4    // {funct7[5], funct3}.
`define RD_DIN_SEL_WIDTH    2
`define PC_NEXT_SEL_WIDTH   2
`define ALU_DIN1_SEL_WIDTH  2
`define ALU_DIN2_SEL_WIDTH  2
`define ALU_OP_WIDTH        2

// ----------------------------------------
// Codes
// ----------------------------------------
`define INST_TYPE_NONE      3'd0
`define INST_TYPE_IMM       3'd1  // LUI.
`define INST_TYPE_INT_IMM   3'd2
`define INST_TYPE_INT_REG   3'd3
`define INST_TYPE_BRANCH    3'd4

`define FUNCT_ADD           4'b0000
`define FUNCT_SUB           4'b1000
`define FUNCT_EQ            4'b0000

`define PC_NEXT_SEL_STALL   2'd0
`define PC_NEXT_SEL_INCR    2'd1
`define PC_NEXT_SEL_BRANCH  2'd2

`define RD_DIN_SEL_IMM      2'd0
`define RD_DIN_SEL_ALU      2'd1

`define ALU_DIN1_SEL_RS1    2'd0

`define ALU_DIN2_SEL_RS2    2'd0
`define ALU_DIN2_SEL_IMM    2'd1

`define ALU_OP_NOP          2'd0
`define ALU_OP_ADD          2'd1
`define ALU_OP_SUB          2'd2

`define OPCODE_LUI          7'b0110111
`define OPCODE_INT_IMM      7'b0010011
`define OPCODE_INT_REG      7'b0110011
`define OPCODE_BRANCH       7'b1100011

`define RESET_PC            32'd0

`endif

// File: copperv_pkg.sv
`default_nettype none

`include "copperv_params.svh"

package copperv_pkg;

    // ----------------------------------------
    // Datapath values
    // ----------------------------------------
    typedef logic [`WORD_WIDTH-1:0]     word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

    // ----------------------------------------
    // Decode and control fields
    // ----------------------------------------
    typedef logic [`INST_TYPE_WIDTH-1:0]    inst_type_t;
    typedef logic [`FUNCT_WIDTH-1:0]        funct_t;
    typedef logic [`RD_DIN_SEL_WIDTH-1:0]   rd_din_sel_t;
    typedef logic [`PC_NEXT_SEL_WIDTH-1:0]  pc_next_sel_t;
    typedef logic [`ALU_DIN1_SEL_WIDTH-1:0] alu_din1_sel_t;
    typedef logic [`ALU_DIN2_SEL_WIDTH-1:0] alu_din2_sel_t;
    typedef logic [`ALU_OP_WIDTH-1:0]       alu_op_t;

    // Multicycle sequence of the control unit.
    typedef enum logic [2:0] {
        RESET,
        IDLE,
        FETCH,
        LOAD,
        EXEC,
        MEM
    } state_t;

endpackage

`default_nettype wire

// File: copperv_ifs.sv
`default_nettype none

// Decoded instruction fields.
interface decode_if;
    copperv_pkg::inst_type_t inst_type;
    copperv_pkg::funct_t     funct;
    copperv_pkg::word_t      imm;
    copperv_pkg::reg_addr_t  rd;
    copperv_pkg::reg_addr_t  rs1;
    copperv_pkg::reg_addr_t  rs2;

    modport src (output inst_type, funct, imm, rd, rs1, rs2);
    modport dst (input  inst_type, funct, imm, rd, rs1, rs2);
endinterface

// Datapath steering from the control unit.
interface ctrl_if;
    logic                       rd_en;
    logic                       rs1_en;
    logic                       rs2_en;
    copperv_pkg::rd_din_sel_t   rd_din_sel;
    copperv_pkg::pc_next_sel_t  pc_next_sel;
    copperv_pkg::alu_din1_sel_t alu_din1_sel;
    copperv_pkg::alu_din2_sel_t alu_din2_sel;
    logic                       rcomp_en;
    copperv_pkg::alu_op_t       alu_op;

    modport ctrl (output rd_en, rs1_en, rs2_en, rd_din_sel, pc_next_sel,
                  alu_din1_sel, alu_din2_sel, rcomp_en, alu_op);
    modport dp   (input  rd_en, rs1_en, rs2_en, rd_din_sel, pc_next_sel,
                  alu_din1_sel, alu_din2_sel, rcomp_en, alu_op);
endinterface

`default_nettype wire

// File: inst_decoder.sv
`default_nettype none

`include "copperv_params.svh"

module inst_decoder (
    input  logic               clk,
    input  logic               rst,
    input  copperv_pkg::word_t inst,
    input  logic               load,
    decode_if.src              dec
);
    copperv_pkg::word_t inst_q;

    always_ff @(posedge clk) begin
        if (!rst)
            inst_q <= '0;           // Opcode 0 decodes as NONE.
        else if (load)
            inst_q <= inst;
    end

    assign dec.rd  = inst_q[11:7];
    assign dec.rs1 = inst_q[19:15];
    assign dec.rs2 = inst_q[24:20];

    // ----------------------------------------
    // Type and funct
    // ----------------------------------------
    always_comb begin
        case (inst_q[6:0])
            `OPCODE_LUI:     dec.inst_type = `INST_TYPE_IMM;
            `OPCODE_INT_IMM: dec.inst_type = `INST_TYPE_INT_IMM;
            `OPCODE_INT_REG: dec.inst_type = `INST_TYPE_INT_REG;
            `OPCODE_BRANCH:  dec.inst_type = `INST_TYPE_BRANCH;
            default:         dec.inst_type = `INST_TYPE_NONE;
        endcase
    end

    // Only register ops carry a real funct7; ADDI and BEQ see it as zero.
    assign dec.funct = {(dec.inst_type == `INST_TYPE_INT_REG) ? inst_q[30] : 1'b0,
                        inst_q[14:12]};

    // ----------------------------------------
    // Immediate
    // ----------------------------------------
    always_comb begin
        case (dec.inst_type)
            `INST_TYPE_IMM:     dec.imm = {inst_q[31:12], 12'b0};
            `INST_TYPE_INT_IMM: dec.imm = {{20{inst_q[31]}}, inst_q[31:20]};
            `INST_TYPE_BRANCH:  dec.imm = {{19{inst_q[31]}}, inst_q[31], inst_q[7],
                                           inst_q[30:25], inst_q[11:8], 1'b0};
            default:            dec.imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: control_unit.sv
`default_nettype none

`include "copperv_params.svh"

module control_unit (
    input  logic  clk,
    input  logic  rst,
    input  logic  inst_valid,
    input  logic  rcomp,
    decode_if.dst dec,
    ctrl_if.ctrl  ctl,
    output logic  inst_fetch,
    output logic  inst_load
);
    copperv_pkg::state_t state;
    copperv_pkg::state_t state_next;

    always_ff @(posedge clk) begin
        if (!rst)
            state <= copperv_pkg::RESET;
        else
            state <= state_next;
    end

    // ----------------------------------------
    // Next state
    // ----------------------------------------
    always_comb begin
        state_next = copperv_pkg::IDLE;
        case (state)
            copperv_pkg::RESET: state_next = copperv_pkg::FETCH;
            copperv_pkg::IDLE: begin
                if (inst_valid)
                    state_next = copperv_pkg::LOAD;
            end
            copperv_pkg::FETCH: state_next = copperv_pkg::IDLE;
            copperv_pkg::LOAD: begin
                if (dec.inst_type == `INST_TYPE_IMM)
                    state_next = copperv_pkg::FETCH;     // LUI is done.
                else
                    state_next = copperv_pkg::EXEC;
            end
            copperv_pkg::EXEC: state_next = copperv_pkg::FETCH;
            copperv_pkg::MEM: begin
            end
            default: state_next = copperv_pkg::IDLE;
        endcase
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------
    always_comb begin
        inst_fetch       = 1'b0;
        inst_load        = 1'b0;
        ctl.rd_en        = 1'b0;
        ctl.rs1_en       = 1'b0;
        ctl.rs2_en       = 1'b0;
        ctl.rd_din_sel   = `RD_DIN_SEL_IMM;
        ctl.pc_next_sel  = `PC_NEXT_SEL_STALL;
        ctl.alu_din1_sel = `ALU_DIN1_SEL_RS1;
        ctl.alu_din2_sel = `ALU_DIN2_SEL_RS2;
        ctl.rcomp_en     = 1'b0;
        ctl.alu_op       = `ALU_OP_NOP;
        case (state)
            copperv_pkg::IDLE: inst_load = inst_valid;
            copperv_pkg::FETCH: begin
                inst_fetch = 1'b1;
                // Branch decision of the instruction just finished.
                if (dec.inst_type == `INST_TYPE_BRANCH)
                    ctl.pc_next_sel = rcomp ? `PC_NEXT_SEL_BRANCH : `PC_NEXT_SEL_INCR;
            end
            copperv_pkg::LOAD: begin
                case (dec.inst_type)
                    `INST_TYPE_IMM: begin
                        ctl.rd_en       = 1'b1;
                        ctl.pc_next_sel = `PC_NEXT_SEL_INCR;
                    end
                    `INST_TYPE_INT_IMM: ctl.rs1_en = 1'b1;
                    `INST_TYPE_INT_REG, `INST_TYPE_BRANCH: begin
                        ctl.rs1_en = 1'b1;
                        ctl.rs2_en = 1'b1;
                    end
                    default: ;
                endcase
            end
            copperv_pkg::EXEC: begin
                case (dec.inst_type)
                    `INST_TYPE_INT_IMM, `INST_TYPE_INT_REG: begin
                        ctl.rd_en       = 1'b1;
                        ctl.rd_din_sel  = `RD_DIN_SEL_ALU;
                        ctl.pc_next_sel = `PC_NEXT_SEL_INCR;
                        if (dec.inst_type == `INST_TYPE_INT_IMM)
                            ctl.alu_din2_sel = `ALU_DIN2_SEL_IMM;
                        if (dec.funct == `FUNCT_ADD)
                            ctl.alu_op = `ALU_OP_ADD;
                        else if (dec.funct == `FUNCT_SUB)
                            ctl.alu_op = `ALU_OP_SUB;
                    end
                    `INST_TYPE_BRANCH: begin
                        if (dec.funct == `FUNCT_EQ)
                            ctl.rcomp_en = 1'b1;
                    end
                    default: ctl.pc_next_sel = `PC_NEXT_SEL_INCR;   // No-op.
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: program_counter.sv
`default_nettype none

`include "copperv_params.svh"

module program_counter (
    input  logic               clk,
    input  logic               rst,
    ctrl_if.dp                 ctl,
    decode_if.dst              dec,
    output copperv_pkg::word_t pc
);

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc <= `RESET_PC;
        end else begin
            case (ctl.pc_next_sel)
                `PC_NEXT_SEL_INCR:   pc <= pc + 32'd4;
                `PC_NEXT_SEL_BRANCH: pc <= pc + dec.imm;   // B-type offset.
                default:             pc <= pc;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: reg_file.sv
`default_nettype none

`include "copperv_params.svh"

module reg_file (
    input  logic               clk,
    input  logic               rst,
    ctrl_if.dp                 ctl,
    decode_if.dst              dec,
    input  copperv_pkg::word_t alu_dout,
    output copperv_pkg::word_t rd_din,
    output copperv_pkg::word_t rs1_dout,
    output copperv_pkg::word_t rs2_dout
);
    copperv_pkg::word_t regs [32];

    // Write-back source.
    always_comb begin
        case (ctl.rd_din_sel)
            `RD_DIN_SEL_IMM: rd_din = dec.imm;
            `RD_DIN_SEL_ALU: rd_din = alu_dout;
            default:         rd_din = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
            rs1_dout <= '0;
            rs2_dout <= '0;
        end else begin
            if (ctl.rd_en && dec.rd != '0)
                regs[dec.rd] <= rd_din;    // x0 stays zero.
            if (ctl.rs1_en)
                rs1_dout <= regs[dec.rs1];
            if (ctl.rs2_en)
                rs2_dout <= regs[dec.rs2];
        end
    end

endmodule

`default_nettype wire

// File: alu.sv
`default_nettype none

`include "copperv_params.svh"

module alu (
    input  logic               clk,
    input  logic               rst,
    ctrl_if.dp                 ctl,
    decode_if.dst              dec,
    input  copperv_pkg::word_t rs1_dout,
    input  copperv_pkg::word_t rs2_dout,
    output copperv_pkg::word_t alu_dout,
    output logic               rcomp
);
    copperv_pkg::word_t din1;
    copperv_pkg::word_t din2;

    assign din1 = (ctl.alu_din1_sel == `ALU_DIN1_SEL_RS1) ? rs1_dout : '0;
    assign din2 = (ctl.alu_din2_sel == `ALU_DIN2_SEL_IMM) ? dec.imm  : rs2_dout;

    always_comb begin
        case (ctl.alu_op)
            `ALU_OP_ADD: alu_dout = din1 + din2;
            `ALU_OP_SUB: alu_dout = din1 - din2;
            default:     alu_dout = '0;
        endcase
    end

    // Equality flag, held for the branch decision in the next FETCH.
    always_ff @(posedge clk) begin
        if (!rst)
            rcomp <= 1'b0;
        else if (ctl.rd_en)
            rcomp <= 1'b0;
        else if (ctl.rcomp_en)
            rcomp <= (rs1_dout == rs2_dout);
    end

endmodule

`default_nettype wire

// File: copperv_core.sv
`default_nettype none

module copperv_core (
    input  logic                   clk,
    input  logic                   rst,
    input  copperv_pkg::word_t     inst,
    input  logic                   inst_valid,
    output logic                   inst_fetch,
    output copperv_pkg::word_t     pc,
    output logic                   wb_en,
    output copperv_pkg::reg_addr_t wb_addr,
    output copperv_pkg::word_t     wb_data
);
    logic               inst_load;
    logic               rcomp;
    copperv_pkg::word_t rd_din;
    copperv_pkg::word_t rs1_dout;
    copperv_pkg::word_t rs2_dout;
    copperv_pkg::word_t alu_dout;

    decode_if dec_bus ();
    ctrl_if   ctl_bus ();

    // ----------------------------------------
    // Blocks
    // ----------------------------------------
    inst_decoder u_inst_decoder (
        .clk  (clk),
        .rst  (rst),
        .inst (inst),
        .load (inst_load),
        .dec  (dec_bus)
    );

    control_unit u_control_unit (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .rcomp      (rcomp),
        .dec        (dec_bus),
        .ctl        (ctl_bus),
        .inst_fetch (inst_fetch),
        .inst_load  (inst_load)
    );

    program_counter u_program_counter (
        .clk (clk),
        .rst (rst),
        .ctl (ctl_bus),
        .dec (dec_bus),
        .pc  (pc)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .ctl      (ctl_bus),
        .dec      (dec_bus),
        .alu_dout (alu_dout),
        .rd_din   (rd_din),
        .rs1_dout (rs1_dout),
        .rs2_dout (rs2_dout)
    );

    alu u_alu (
        .clk      (clk),
        .rst      (rst),
        .ctl      (ctl_bus),
        .dec      (dec_bus),
        .rs1_dout (rs1_dout),
        .rs2_dout (rs2_dout),
        .alu_dout (alu_dout),
        .rcomp    (rcomp)
    );

    // Write-back trace, zero between writes.
    assign wb_en   = ctl_bus.rd_en;
    assign wb_addr = ctl_bus.rd_en ? dec_bus.rd : '0;
    assign wb_data = ctl_bus.rd_en ? rd_din : '0;

endmodule

`default_nettype wire

// File: copperv_tb.sv
`default_nettype none

`include "copperv_params.svh"

module copperv_tb;

    localparam int NUM_ROWS   = 18;
    localparam int CLK_PERIOD = 20;
    localparam int TIMEOUT    = (NUM_ROWS * 12 + 5) * CLK_PERIOD;

    typedef enum {OP_LUI, OP_ADDI, OP_ADD, OP_SUB, OP_BEQ, OP_BAD} op_kind_t;

    logic                   clk;
    logic                   rst;
    copperv_pkg::word_t     inst;
    logic                   inst_valid;
    logic                   inst_fetch;
    copperv_pkg::word_t     pc;
    logic                   wb_en;
    copperv_pkg::reg_addr_t wb_addr;
    copperv_pkg::word_t     wb_data;

    // ----------------------------------------
    // Stimulus table and model state
    // ----------------------------------------
    op_kind_t               op_tab    [NUM_ROWS];
    copperv_pkg::reg_addr_t rd_tab    [NUM_ROWS];
    copperv_pkg::reg_addr_t rs1_tab   [NUM_ROWS];
    copperv_pkg::reg_addr_t rs2_tab   [NUM_ROWS];
    int                     imm_tab   [NUM_ROWS];
    copperv_pkg::word_t     inst_tab  [NUM_ROWS];
    logic                   exp_we    [NUM_ROWS];
    copperv_pkg::word_t     exp_val   [NUM_ROWS];
    int                     exp_lat   [NUM_ROWS];
    logic                   is_branch [NUM_ROWS];
    copperv_pkg::word_t     row_pc    [NUM_ROWS+1];   // Last entry is the PC after the table.
    copperv_pkg::word_t     model_regs [32];

    integer seed = 81;

    copperv_core UUT (
        .clk        (clk),
        .rst        (rst),
        .inst       (inst),
        .inst_valid (inst_valid),
        .inst_fetch (inst_fetch),
        .pc         (pc),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ----------------------------------------
    // Instruction encoders
    // ----------------------------------------
    function automatic copperv_pkg::word_t lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, `OPCODE_LUI};
    endfunction

    function automatic copperv_pkg::word_t addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                                     input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, `OPCODE_INT_IMM};
    endfunction

    function automatic copperv_pkg::word_t reg_op_word(input logic sub, input logic [4:0] rd,
                                                       input logic [4:0] rs1,
                                                       input logic [4:0] rs2);
        return {1'b0, sub, 5'b00000, rs2, rs1, 3'b000, rd, `OPCODE_INT_REG};
    endfunction

    function automatic copperv_pkg::word_t beq_word(input logic [4:0] rs1, input logic [4:0] rs2,
                                                    input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], `OPCODE_BRANCH};
    endfunction

    task set_row(input int i, input op_kind_t op, input logic [4:0] rd,
                 input logic [4:0] rs1, input logic [4:0] rs2, input int imm);
        op_tab[i]  = op;
        rd_tab[i]  = rd;
        rs1_tab[i] = rs1;
        rs2_tab[i] = rs2;
        imm_tab[i] = imm;
        case (op)
            OP_LUI:  inst_tab[i] = lui_word(rd, imm[19:0]);
            OP_ADDI: inst_tab[i] = addi_word(rd, rs1, imm[11:0]);
            OP_ADD:  inst_tab[i] = reg_op_word(1'b0, rd, rs1, rs2);
            OP_SUB:  inst_tab[i] = reg_op_word(1'b1, rd, rs1, rs2);
            OP_BEQ:  inst_tab[i] = beq_word(rs1, rs2, imm[12:0]);
            default: inst_tab[i] = 32'h0000_0073;       // SYSTEM opcode, unsupported.
        endcase
    endtask

    task build_table();
        set_row(0,  OP_LUI,  5'd1,  5'd0,  5'd0,  'h12345);
        set_row(1,  OP_ADDI, 5'd2,  5'd0,  5'd0,  100);
        set_row(2,  OP_ADDI, 5'd3,  5'd2,  5'd0,  -200);     // Negative immediate.
        set_row(3,  OP_ADD,  5'd4,  5'd1,  5'd3,  0);
        set_row(4,  OP_SUB,  5'd5,  5'd2,  5'd3,  0);
        set_row(5,  OP_ADDI, 5'd0,  5'd1,  5'd0,  5);        // Write to x0.
        set_row(6,  OP_ADD,  5'd6,  5'd0,  5'd2,  0);
        set_row(7,  OP_BEQ,  5'd0,  5'd2,  5'd6,  16);       // Taken.
        set_row(8,  OP_BEQ,  5'd0,  5'd1,  5'd2,  8);        // Not taken.
        set_row(9,  OP_BAD,  5'd0,  5'd0,  5'd0,  0);        // Unsupported opcode.
        set_row(10, OP_BEQ,  5'd0,  5'd0,  5'd0,  -12);      // Taken, backward.
        set_row(11, OP_SUB,  5'd9,  5'd0,  5'd1,  0);
        set_row(12, OP_LUI,  5'd7,  5'd0,  5'd0,  'hFFFFF);
        set_row(13, OP_ADD,  5'd10, 5'd7,  5'd7,  0);
        set_row(14, OP_LUI,  5'd11, 5'd0,  5'd0,  'h80000);
        set_row(15, OP_ADD,  5'd12, 5'd11, 5'd11, 0);        // Wraps to zero.
        set_row(16, OP_BEQ,  5'd0,  5'd12, 5'd0,  32);
        set_row(17, OP_ADDI, 5'd13, 5'd12, 5'd0,  -1);
    endtask

    // Reference model of the instruction rules.
    task run_model();
        copperv_pkg::word_t a;
        copperv_pkg::word_t b;
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        row_pc[0] = `RESET_PC;
        for (int i = 0; i < NUM_ROWS; i++) begin
            a = model_regs[rs1_tab[i]];
            b = model_regs[rs2_tab[i]];
            exp_we[i] = 1'b1;
            exp_val[i] = '0;
            exp_lat[i] = 2;
            is_branch[i] = 1'b0;
            row_pc[i+1] = row_pc[i] + 32'd4;
            case (op_tab[i])
                OP_LUI: begin
                    exp_val[i] = imm_tab[i] << 12;
                    exp_lat[i] = 1;
                end
                OP_ADDI: exp_val[i] = a + imm_tab[i];
                OP_ADD:  exp_val[i] = a + b;
                OP_SUB:  exp_val[i] = a - b;
                OP_BEQ: begin
                    exp_we[i] = 1'b0;
                    is_branch[i] = 1'b1;
                    if (a == b)
                        row_pc[i+1] = row_pc[i] + imm_tab[i];
                end
                default: exp_we[i] = 1'b0;
            endcase
            if (exp_we[i] && rd_tab[i] != 5'd0)
                model_regs[rd_tab[i]] = exp_val[i];
        end
    endtask

    task report_error(input string msg);
        $display("ERR @ %0t: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "Stopped at the first error.");
    endtask

    // ----------------------------------------
    // Fetch pulse before row i, and the PC one cycle on
    // ----------------------------------------
    task check_fetch(input int i);
        copperv_pkg::word_t fetch_pc;
        if (i == 0)
            fetch_pc = `RESET_PC;
        else if (is_branch[i-1])
            fetch_pc = row_pc[i-1];      // Branch resolves after this pulse.
        else
            fetch_pc = row_pc[i];
        assert (pc == fetch_pc)
            else report_error($sformatf("row %0d fetch pc %h, expected %h", i, pc, fetch_pc));
        @(posedge clk);
        #2;
        assert (pc == row_pc[i])
            else report_error($sformatf("row %0d pc %h, expected %h", i, pc, row_pc[i]));
        assert (!inst_fetch && !wb_en && wb_addr == '0 && wb_data == '0)
            else report_error($sformatf("row %0d outputs not idle", i));
    endtask

    // ----------------------------------------
    // One table row, from IDLE to the next fetch pulse
    // ----------------------------------------
    task run_row(input int i);
        int gap;
        int n;
        int wb_count;
        gap = $random(seed) & 3;
        repeat (gap) begin
            @(posedge clk);
            #2;
        end
        inst = inst_tab[i];
        inst_valid = 1'b1;
        @(posedge clk);
        #2;
        inst_valid = 1'b0;
        inst = $random(seed);            // Ignored outside IDLE.
        n = 0;
        wb_count = 0;
        do begin
            @(negedge clk);
            n++;
            if (wb_en) begin
                wb_count++;
                assert (n == exp_lat[i])
                    else report_error($sformatf("row %0d wb_en after %0d cycles", i, n));
                assert (wb_addr == rd_tab[i])
                    else report_error($sformatf("row %0d wb_addr %0d, expected %0d",
                                                i, wb_addr, rd_tab[i]));
                assert (wb_data == exp_val[i])
                    else report_error($sformatf("row %0d wb_data %h, expected %h",
                                                i, wb_data, exp_val[i]));
            end
        end while (!inst_fetch);
        assert (wb_count == (exp_we[i] ? 1 : 0))
            else report_error($sformatf("row %0d saw %0d write-backs", i, wb_count));
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        inst = '0;
        inst_valid = 1'b0;
        build_table();
        run_model();
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b1;
        @(negedge clk);
        assert (pc == `RESET_PC && !wb_en && !inst_fetch)
            else report_error($sformatf("after reset pc %h wb_en %b", pc, wb_en));
        do
            @(negedge clk);
        while (!inst_fetch);
        for (int i = 0; i < NUM_ROWS; i++) begin
            check_fetch(i);
            run_row(i);
        end
        check_fetch(NUM_ROWS);
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: the core did not get through the instruction table in time.");
        $display("Result: FAILED");
        $fatal(1, "Watchdog expired.");
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
copperv_pkg.sv
copperv_ifs.sv
inst_decoder.sv
control_unit.sv
program_counter.sv
reg_file.sv
alu.sv
copperv_core.sv
copperv_tb.sv

// File: Bender.yml
package:
  name: copperv

export_include_dirs:
  - .

sources:
  - copperv_pkg.sv
  - copperv_ifs.sv
  - inst_decoder.sv
  - control_unit.sv
  - program_counter.sv
  - reg_file.sv
  - alu.sv
  - copperv_core.sv
  - target: test
    files:
      - copperv_tb.sv
